// File: design/dtim_pkg.sv
`default_nettype none

package dtim_pkg;

  // Data word on the CPU and memory ports.
  typedef logic [31:0] word_t;

  // Byte address.
  typedef logic [31:0] addr_t;

  // Byte write enables, all zero for a read.
  typedef logic [3:0] strb_t;

  //////////////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    hit       = 3'd0,
    miss      = 3'd1,
    ldst      = 3'd2,
    update    = 3'd3,
    fence     = 3'd4,
    writeback = 3'd5
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/dtim_array.sv
`timescale 1ns/1ns
`default_nettype none

module dtim_array #(
  parameter type payload_t = logic,
  parameter int depth_bits = 4
) (
  input  wire                  clk,
  input  wire [depth_bits-1:0] rd_addr,
  output payload_t             rd_data,
  input  wire                  wr_en,
  input  wire [depth_bits-1:0] wr_addr,
  input  wire payload_t        wr_data
);

  // All entries start at zero, so every line comes up unlocked and clean.
  payload_t store [2**depth_bits] = '{default: '0};

  logic [depth_bits-1:0] rd_addr_q = '0;

  always_ff @(posedge clk) begin
    rd_addr_q <= rd_addr;
    if (wr_en) begin
      store[wr_addr] <= wr_data;
    end
  end

  // Data for last cycle's address.
  // A write lands at the edge, so this cycle still shows the old entry.
  assign rd_data = store[rd_addr_q];

endmodule

`default_nettype wire

// File: design/dtim_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dtim_ctrl #(
  parameter int              depth_bits = 4,
  parameter int              word_bits  = 2,
  parameter dtim_pkg::addr_t base_addr  = 32'h1000,
  parameter dtim_pkg::addr_t top_addr   = 32'h2000,
  localparam int             tag_bits   = 30 - depth_bits - word_bits,
  localparam int             line_bits  = 32 << word_bits
) (
  input  wire                   clk,
  input  wire                   rst,
  // CPU load/store port.
  input  wire                   cpu_valid,
  input  wire                   cpu_fence,
  input  wire dtim_pkg::addr_t  cpu_addr,
  input  wire dtim_pkg::word_t  cpu_wdata,
  input  wire dtim_pkg::strb_t  cpu_wstrb,
  output dtim_pkg::word_t       cpu_rdata,
  output logic                  cpu_ready,
  // External data memory.
  output logic                  mem_valid,
  output dtim_pkg::addr_t       mem_addr,
  output dtim_pkg::word_t       mem_wdata,
  output dtim_pkg::strb_t       mem_wstrb,
  input  wire dtim_pkg::word_t  mem_rdata,
  input  wire                   mem_ready,
  // Tag array.
  output logic [depth_bits-1:0] tag_rd_addr,
  input  wire [tag_bits-1:0]    tag_rd_data,
  output logic                  tag_wr_en,
  output logic [depth_bits-1:0] tag_wr_addr,
  output logic [tag_bits-1:0]   tag_wr_data,
  // Line array.
  output logic [depth_bits-1:0] line_rd_addr,
  input  wire [line_bits-1:0]   line_rd_data,
  output logic                  line_wr_en,
  output logic [depth_bits-1:0] line_wr_addr,
  output logic [line_bits-1:0]  line_wr_data,
  // Flags array, lock in bit 1 and dirty in bit 0.
  output logic [depth_bits-1:0] flags_rd_addr,
  input  wire [1:0]             flags_rd_data,
  output logic                  flags_wr_en,
  output logic [depth_bits-1:0] flags_wr_addr,
  output logic [1:0]            flags_wr_data
);

  // Front register.
  logic                  f_rd, f_rd_n;
  logic                  f_wr, f_wr_n;
  logic                  f_fence, f_fence_n;
  dtim_pkg::addr_t       f_addr, f_addr_n;
  dtim_pkg::word_t       f_wdata, f_wdata_n;
  dtim_pkg::strb_t       f_strb, f_strb_n;
  logic [tag_bits-1:0]   f_tag, f_tag_n;
  logic [depth_bits-1:0] f_idx, f_idx_n;
  logic [word_bits-1:0]  f_wid, f_wid_n;

  // Back register.
  dtim_pkg::ctrl_state_t state, state_n;
  logic [tag_bits-1:0]   b_tag, b_tag_n;
  logic [depth_bits-1:0] b_idx, b_idx_n;
  logic [word_bits-1:0]  b_wid, b_wid_n;
  logic [word_bits-1:0]  b_cnt, b_cnt_n;
  logic [line_bits-1:0]  b_line, b_line_n;
  dtim_pkg::strb_t       b_strb, b_strb_n;
  dtim_pkg::word_t       b_sdata, b_sdata_n;
  logic                  m_valid, m_valid_n;
  dtim_pkg::addr_t       m_addr, m_addr_n;
  dtim_pkg::word_t       m_wdata, m_wdata_n;
  dtim_pkg::strb_t       m_strb, m_strb_n;

  logic                  f_req;
  logic                  in_window;
  logic                  line_lock;
  logic                  line_dirty;
  logic                  tag_match;
  logic                  line_hit;
  logic [depth_bits-1:0] wr_idx;
  logic [line_bits-1:0]  fill_line;
  logic [line_bits-1:0]  hit_line;
  logic [line_bits-1:0]  miss_line;

  // Merge the strobed bytes of one word into a line.
  function automatic logic [line_bits-1:0] merge_word(
    input logic [line_bits-1:0] line,
    input logic [word_bits-1:0] wid,
    input dtim_pkg::strb_t      strb,
    input dtim_pkg::word_t      data
  );
    logic [line_bits-1:0] res;
    dtim_pkg::word_t      word;
    res  = line;
    word = line[32*wid +: 32];
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    res[32*wid +: 32] = word;
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Request classification
  //////////////////////////////////////////////////////////////////////

  assign f_req      = f_rd | f_wr;
  assign in_window  = (f_addr >= base_addr) && (f_addr < top_addr);
  assign line_lock  = flags_rd_data[1];
  assign line_dirty = flags_rd_data[0];
  assign tag_match  = (tag_rd_data == f_tag);
  assign line_hit   = in_window & line_lock & tag_match;

  // Line buffer with the returning fill word in place.
  always_comb begin
    fill_line = b_line;
    fill_line[32*b_cnt +: 32] = mem_rdata;
  end

  assign hit_line  = merge_word(line_rd_data, f_wid, f_strb, f_wdata);
  // A pending load has a zero strobe and leaves the fill untouched.
  assign miss_line = merge_word(fill_line, b_wid, b_strb, b_sdata);

  //////////////////////////////////////////////////////////////////////
  // Back state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n       = state;
    b_tag_n       = b_tag;
    b_idx_n       = b_idx;
    b_wid_n       = b_wid;
    b_cnt_n       = b_cnt;
    b_line_n      = b_line;
    b_strb_n      = b_strb;
    b_sdata_n     = b_sdata;
    m_valid_n     = 1'b0;
    m_addr_n      = m_addr;
    m_wdata_n     = m_wdata;
    m_strb_n      = m_strb;
    tag_wr_en     = 1'b0;
    line_wr_en    = 1'b0;
    flags_wr_en   = 1'b0;
    wr_idx        = b_idx;
    tag_wr_data   = b_tag;
    line_wr_data  = miss_line;
    flags_wr_data = {1'b1, |b_strb};

    case (state)
      dtim_pkg::hit: begin
        if (f_fence) begin
          state_n = dtim_pkg::fence;
          b_idx_n = '0;
        end else if (f_req && (!in_window || (line_lock && !tag_match))) begin
          // Outside the window, or a conflict with the locked line.
          state_n   = dtim_pkg::ldst;
          m_valid_n = 1'b1;
          m_addr_n  = f_addr;
          m_wdata_n = f_wdata;
          m_strb_n  = f_strb;
        end else if (f_req && !line_lock) begin
          state_n   = dtim_pkg::miss;
          m_valid_n = 1'b1;
          m_addr_n  = {f_addr[31:word_bits+2], {(word_bits+2){1'b0}}};
          m_strb_n  = '0;
          b_tag_n   = f_tag;
          b_idx_n   = f_idx;
          b_wid_n   = f_wid;
          b_cnt_n   = '0;
          b_strb_n  = f_strb;
          b_sdata_n = f_wdata;
        end else if (f_wr) begin
          state_n       = dtim_pkg::update;
          b_line_n      = hit_line;
          b_wid_n       = f_wid;
          tag_wr_en     = 1'b1;
          line_wr_en    = 1'b1;
          flags_wr_en   = 1'b1;
          wr_idx        = f_idx;
          tag_wr_data   = f_tag;
          line_wr_data  = hit_line;
          flags_wr_data = 2'b11;
        end
      end
      dtim_pkg::miss: begin
        if (mem_ready) begin
          if (&b_cnt) begin
            // Last word. Lock the line, dirty only for a store.
            state_n     = dtim_pkg::update;
            b_line_n    = miss_line;
            tag_wr_en   = 1'b1;
            line_wr_en  = 1'b1;
            flags_wr_en = 1'b1;
          end else begin
            b_line_n  = fill_line;
            b_cnt_n   = b_cnt + 1'b1;
            m_valid_n = 1'b1;
            m_addr_n  = m_addr + 32'd4;
          end
        end
      end
      dtim_pkg::ldst: begin
        if (mem_ready) begin
          state_n = dtim_pkg::hit;
        end
      end
      dtim_pkg::update: begin
        state_n = dtim_pkg::hit;
      end
      dtim_pkg::fence: begin
        if (line_lock && line_dirty) begin
          state_n   = dtim_pkg::writeback;
          b_line_n  = line_rd_data;
          b_cnt_n   = '0;
          m_valid_n = 1'b1;
          m_addr_n  = {tag_rd_data, b_idx, {(word_bits+2){1'b0}}};
          m_wdata_n = line_rd_data[31:0];
          m_strb_n  = 4'hf;
        end else begin
          flags_wr_en   = 1'b1;
          flags_wr_data = 2'b00;
          if (&b_idx) begin
            state_n = dtim_pkg::update;
          end else begin
            b_idx_n = b_idx + 1'b1;
          end
        end
      end
      dtim_pkg::writeback: begin
        if (mem_ready) begin
          if (&b_cnt) begin
            flags_wr_en   = 1'b1;
            flags_wr_data = 2'b00;
            if (&b_idx) begin
              state_n = dtim_pkg::update;
            end else begin
              state_n = dtim_pkg::fence;
              b_idx_n = b_idx + 1'b1;
            end
          end else begin
            b_cnt_n   = b_cnt + 1'b1;
            m_valid_n = 1'b1;
            m_addr_n  = m_addr + 32'd4;
            m_wdata_n = b_line[32*b_cnt_n +: 32];
          end
        end
      end
      default: begin
        state_n = dtim_pkg::hit;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Front request register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    f_rd_n    = 1'b0;
    f_wr_n    = 1'b0;
    f_fence_n = 1'b0;
    f_addr_n  = f_addr;
    f_wdata_n = f_wdata;
    f_strb_n  = f_strb;
    f_tag_n   = f_tag;
    f_idx_n   = f_idx;
    f_wid_n   = f_wid;
    if (cpu_valid) begin
      if (cpu_fence) begin
        f_fence_n = 1'b1;
      end else begin
        f_rd_n    = ~(|cpu_wstrb);
        f_wr_n    = |cpu_wstrb;
        f_addr_n  = cpu_addr;
        f_wdata_n = cpu_wdata;
        f_strb_n  = cpu_wstrb;
        f_tag_n   = cpu_addr[31 -: tag_bits];
        f_idx_n   = cpu_addr[word_bits+2 +: depth_bits];
        f_wid_n   = cpu_addr[2 +: word_bits];
      end
    end
    // The sweep steers the read index.
    if (state_n == dtim_pkg::fence || state_n == dtim_pkg::writeback) begin
      f_idx_n = b_idx_n;
    end
  end

  assign tag_rd_addr   = f_idx_n;
  assign line_rd_addr  = f_idx_n;
  assign flags_rd_addr = f_idx_n;
  assign tag_wr_addr   = wr_idx;
  assign line_wr_addr  = wr_idx;
  assign flags_wr_addr = wr_idx;

  //////////////////////////////////////////////////////////////////////
  // Port outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cpu_ready = 1'b0;
    cpu_rdata = b_line[32*b_wid +: 32];
    case (state)
      dtim_pkg::hit: begin
        cpu_ready = f_rd & line_hit;
        cpu_rdata = line_rd_data[32*f_wid +: 32];
      end
      dtim_pkg::ldst: begin
        cpu_ready = mem_ready;
        cpu_rdata = mem_rdata;
      end
      dtim_pkg::update: begin
        cpu_ready = 1'b1;
      end
      default: begin
        cpu_ready = 1'b0;
      end
    endcase
  end

  assign mem_valid = m_valid;
  assign mem_addr  = m_addr;
  assign mem_wdata = m_wdata;
  assign mem_wstrb = m_strb;

  always_ff @(posedge clk) begin
    if (!rst) begin
      f_rd    <= 1'b0;
      f_wr    <= 1'b0;
      f_fence <= 1'b0;
      f_idx   <= '0;
      state   <= dtim_pkg::hit;
      m_valid <= 1'b0;
    end else begin
      f_rd    <= f_rd_n;
      f_wr    <= f_wr_n;
      f_fence <= f_fence_n;
      f_idx   <= f_idx_n;
      state   <= state_n;
      m_valid <= m_valid_n;
    end
  end

  always_ff @(posedge clk) begin
    f_addr  <= f_addr_n;
    f_wdata <= f_wdata_n;
    f_strb  <= f_strb_n;
    f_tag   <= f_tag_n;
    f_wid   <= f_wid_n;
    b_tag   <= b_tag_n;
    b_idx   <= b_idx_n;
    b_wid   <= b_wid_n;
    b_cnt   <= b_cnt_n;
    b_line  <= b_line_n;
    b_strb  <= b_strb_n;
    b_sdata <= b_sdata_n;
    m_addr  <= m_addr_n;
    m_wdata <= m_wdata_n;
    m_strb  <= m_strb_n;
  end

endmodule

`default_nettype wire

// File: design/dtim.sv
`timescale 1ns/1ns
`default_nettype none

module dtim #(
  parameter int              depth_bits = 4,
  parameter int              word_bits  = 2,
  parameter dtim_pkg::addr_t base_addr  = 32'h1000,
  parameter dtim_pkg::addr_t top_addr   = 32'h2000
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  cpu_valid,
  input  wire                  cpu_fence,
  input  wire dtim_pkg::addr_t cpu_addr,
  input  wire dtim_pkg::word_t cpu_wdata,
  input  wire dtim_pkg::strb_t cpu_wstrb,
  output dtim_pkg::word_t      cpu_rdata,
  output logic                 cpu_ready,
  output logic                 mem_valid,
  output dtim_pkg::addr_t      mem_addr,
  output dtim_pkg::word_t      mem_wdata,
  output dtim_pkg::strb_t      mem_wstrb,
  input  wire dtim_pkg::word_t mem_rdata,
  input  wire                  mem_ready
);

  localparam int tag_bits  = 30 - depth_bits - word_bits;
  localparam int line_bits = 32 << word_bits;

  typedef logic [tag_bits-1:0]  tag_t;
  typedef logic [line_bits-1:0] line_t;
  // Lock, then dirty.
  typedef logic [1:0]           flags_t;

  logic [depth_bits-1:0] tag_rd_addr;
  tag_t                  tag_rd_data;
  logic                  tag_wr_en;
  logic [depth_bits-1:0] tag_wr_addr;
  tag_t                  tag_wr_data;

  logic [depth_bits-1:0] line_rd_addr;
  line_t                 line_rd_data;
  logic                  line_wr_en;
  logic [depth_bits-1:0] line_wr_addr;
  line_t                 line_wr_data;

  logic [depth_bits-1:0] flags_rd_addr;
  flags_t                flags_rd_data;
  logic                  flags_wr_en;
  logic [depth_bits-1:0] flags_wr_addr;
  flags_t                flags_wr_data;

  dtim_ctrl #(
    .depth_bits (depth_bits),
    .word_bits  (word_bits),
    .base_addr  (base_addr),
    .top_addr   (top_addr)
  ) u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .cpu_valid     (cpu_valid),
    .cpu_fence     (cpu_fence),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_wstrb     (cpu_wstrb),
    .cpu_rdata     (cpu_rdata),
    .cpu_ready     (cpu_ready),
    .mem_valid     (mem_valid),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_wstrb     (mem_wstrb),
    .mem_rdata     (mem_rdata),
    .mem_ready     (mem_ready),
    .tag_rd_addr   (tag_rd_addr),
    .tag_rd_data   (tag_rd_data),
    .tag_wr_en     (tag_wr_en),
    .tag_wr_addr   (tag_wr_addr),
    .tag_wr_data   (tag_wr_data),
    .line_rd_addr  (line_rd_addr),
    .line_rd_data  (line_rd_data),
    .line_wr_en    (line_wr_en),
    .line_wr_addr  (line_wr_addr),
    .line_wr_data  (line_wr_data),
    .flags_rd_addr (flags_rd_addr),
    .flags_rd_data (flags_rd_data),
    .flags_wr_en   (flags_wr_en),
    .flags_wr_addr (flags_wr_addr),
    .flags_wr_data (flags_wr_data)
  );

  dtim_array #(
    .payload_t  (tag_t),
    .depth_bits (depth_bits)
  ) u_tag (
    .clk     (clk),
    .rd_addr (tag_rd_addr),
    .rd_data (tag_rd_data),
    .wr_en   (tag_wr_en),
    .wr_addr (tag_wr_addr),
    .wr_data (tag_wr_data)
  );

  dtim_array #(
    .payload_t  (line_t),
    .depth_bits (depth_bits)
  ) u_line (
    .clk     (clk),
    .rd_addr (line_rd_addr),
    .rd_data (line_rd_data),
    .wr_en   (line_wr_en),
    .wr_addr (line_wr_addr),
    .wr_data (line_wr_data)
  );

  dtim_array #(
    .payload_t  (flags_t),
    .depth_bits (depth_bits)
  ) u_flags (
    .clk     (clk),
    .rd_addr (flags_rd_addr),
    .rd_data (flags_rd_data),
    .wr_en   (flags_wr_en),
    .wr_addr (flags_wr_addr),
    .wr_data (flags_wr_data)
  );

endmodule

`default_nettype wire

// File: bench/dtim_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dtim_mem_model #(
  parameter int delay = 2,
  parameter int words = 4096
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  mem_valid,
  input  wire dtim_pkg::addr_t mem_addr,
  input  wire dtim_pkg::word_t mem_wdata,
  input  wire dtim_pkg::strb_t mem_wstrb,
  output dtim_pkg::word_t      mem_rdata,
  output logic                 mem_ready
);

  localparam int index_bits = $clog2(words);

  dtim_pkg::word_t       mem [words];
  logic                  busy;
  int                    count;
  logic [index_bits-1:0] idx;
  dtim_pkg::word_t       wdata;
  dtim_pkg::strb_t       wstrb;

  // Every word starts as its own byte address XOR a constant.
  initial begin
    for (int i = 0; i < words; i++) begin
      mem[i] = dtim_pkg::word_t'(i * 4) ^ 32'h5A5A0000;
    end
  end

  // Works on the falling edge, so the DUT sees stable inputs.
  always @(negedge clk) begin
    mem_ready <= 1'b0;
    if (!rst) begin
      busy      <= 1'b0;
      mem_rdata <= '0;
    end else if (mem_valid) begin
      busy  <= 1'b1;
      count <= delay - 1;
      idx   <= mem_addr[index_bits+1:2];
      wdata <= mem_wdata;
      wstrb <= mem_wstrb;
    end else if (busy) begin
      if (count == 0) begin
        busy      <= 1'b0;
        mem_ready <= 1'b1;
        mem_rdata <= mem[idx];
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            mem[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
      end else begin
        count <= count - 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/dtim_assert.sv
`timescale 1ns/1ns
`default_nettype none

module dtim_assert (
  input wire                       clk,
  input wire                       rst,
  input wire                       cpu_valid,
  input wire                       cpu_ready,
  input wire                       mem_valid,
  input wire                       mem_ready,
  input var dtim_pkg::ctrl_state_t state
);

  int   ready_fails = 0;
  int   mem_fails   = 0;
  int   reset_fails = 0;
  int   fail_count;
  logic pending;
  logic mem_busy;

  assign fail_count = ready_fails + mem_fails + reset_fails;

  // Open CPU request and open memory word.
  always_ff @(posedge clk) begin
    if (!rst) begin
      pending  <= 1'b0;
      mem_busy <= 1'b0;
    end else begin
      if (cpu_valid) begin
        pending <= 1'b1;
      end else if (cpu_ready) begin
        pending <= 1'b0;
      end
      if (mem_valid) begin
        mem_busy <= 1'b1;
      end else if (mem_ready) begin
        mem_busy <= 1'b0;
      end
    end
  end

  ready_pending: assert property (@(posedge clk) disable iff (!rst)
    cpu_ready |-> pending)
  else begin
    $error("cpu_ready without a pending request");
    ready_fails++;
  end

  mem_single: assert property (@(posedge clk) disable iff (!rst)
    mem_valid |-> !mem_busy)
  else begin
    $error("mem_valid raised again before mem_ready");
    mem_fails++;
  end

  // Ports quiet and the controller back in hit.
  reset_quiet: assert property (@(posedge clk)
    $rose(rst) |-> (!cpu_ready && !mem_valid && state == dtim_pkg::hit))
  else begin
    $error("ports or controller not idle after reset");
    reset_fails++;
  end

endmodule

bind dtim dtim_assert u_assert (
  .clk       (clk),
  .rst       (rst),
  .cpu_valid (cpu_valid),
  .cpu_ready (cpu_ready),
  .mem_valid (mem_valid),
  .mem_ready (mem_ready),
  .state     (u_ctrl.state)
);

`default_nettype wire

// File: bench/dtim_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dtim_tb;

  localparam int              depth_bits = 4;
  localparam int              word_bits  = 2;
  localparam dtim_pkg::addr_t base_addr  = 32'h1000;
  localparam dtim_pkg::addr_t top_addr   = 32'h2000;
  localparam int              mem_delay  = 2;
  localparam int              mem_words  = 4096;
  localparam int              num_tests  = 6;
  localparam int              line_words = 1 << word_bits;
  // Every line dirty, each word a full memory round trip.
  localparam int fence_cycles = (1 << depth_bits) * (line_words * (mem_delay + 2) + 2);
  localparam int watchdog_cycles = num_tests * fence_cycles * 4;

  logic            clk = 1'b0;
  logic            rst;
  logic            cpu_valid;
  logic            cpu_fence;
  dtim_pkg::addr_t cpu_addr;
  dtim_pkg::word_t cpu_wdata;
  dtim_pkg::strb_t cpu_wstrb;
  dtim_pkg::word_t cpu_rdata;
  logic            cpu_ready;
  logic            mem_valid;
  dtim_pkg::addr_t mem_addr;
  dtim_pkg::word_t mem_wdata;
  dtim_pkg::strb_t mem_wstrb;
  dtim_pkg::word_t mem_rdata;
  logic            mem_ready;

  int              errors    = 0;
  int              mem_count = 0;
  int              assert_fails;
  integer          seed;
  // What the core should see at each word address.
  dtim_pkg::word_t mirror [mem_words];

  always #10 clk = ~clk;

  dtim #(
    .depth_bits (depth_bits),
    .word_bits  (word_bits),
    .base_addr  (base_addr),
    .top_addr   (top_addr)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .cpu_valid (cpu_valid),
    .cpu_fence (cpu_fence),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_wstrb (cpu_wstrb),
    .cpu_rdata (cpu_rdata),
    .cpu_ready (cpu_ready),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready)
  );

  dtim_mem_model #(
    .delay (mem_delay),
    .words (mem_words)
  ) u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready)
  );

  always @(posedge clk) begin
    if (rst && mem_valid) begin
      mem_count <= mem_count + 1;
    end
  end

  function automatic int mirror_slot(input dtim_pkg::addr_t addr);
    return int'(addr[13:2]);
  endfunction

  function automatic dtim_pkg::word_t merge_bytes(
    input dtim_pkg::word_t old,
    input dtim_pkg::word_t data,
    input dtim_pkg::strb_t strb
  );
    dtim_pkg::word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Compare tasks and CPU port driver
  ////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input dtim_pkg::word_t got,
                            input dtim_pkg::word_t exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  // One strobe, then wait for cpu_ready; cycles counts edges after the strobe.
  task automatic cpu_access(input dtim_pkg::addr_t addr, input dtim_pkg::word_t wdata,
                            input dtim_pkg::strb_t strb, input logic fence,
                            output dtim_pkg::word_t rdata, output int cycles);
    logic done;
    @(negedge clk);
    cpu_valid = 1'b1;
    cpu_fence = fence;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_wstrb = strb;
    @(negedge clk);
    cpu_valid = 1'b0;
    cpu_fence = 1'b0;
    cycles    = 0;
    rdata     = '0;
    done      = 1'b0;
    while (!done) begin
      @(posedge clk);
      cycles++;
      if (cpu_ready) begin
        rdata = cpu_rdata;
        done  = 1'b1;
      end else if (cycles >= fence_cycles) begin
        $display("Timeout: no cpu_ready within %0d cycles for the request to %h",
                 fence_cycles, addr);
        errors++;
        done = 1'b1;
      end
    end
  endtask

  task automatic read_word(input dtim_pkg::addr_t addr, input int exp_mem,
                           input int exp_cycles);
    dtim_pkg::word_t rdata;
    int              cycles;
    int              start;
    start = mem_count;
    cpu_access(addr, '0, 4'h0, 1'b0, rdata, cycles);
    check_word($sformatf("cpu_rdata @%h", addr), rdata, mirror[mirror_slot(addr)]);
    if (exp_mem >= 0) begin
      check_count("mem_valid pulses", mem_count - start, exp_mem);
    end
    if (exp_cycles >= 0) begin
      check_count("cpu_ready latency", cycles, exp_cycles);
    end
  endtask

  task automatic write_word(input dtim_pkg::addr_t addr, input dtim_pkg::word_t data,
                            input dtim_pkg::strb_t strb, input int exp_mem,
                            input int exp_cycles);
    dtim_pkg::word_t rdata;
    int              cycles;
    int              start;
    start = mem_count;
    mirror[mirror_slot(addr)] = merge_bytes(mirror[mirror_slot(addr)], data, strb);
    cpu_access(addr, data, strb, 1'b0, rdata, cycles);
    if (exp_mem >= 0) begin
      check_count("mem_valid pulses", mem_count - start, exp_mem);
    end
    if (exp_cycles >= 0) begin
      check_count("cpu_ready latency", cycles, exp_cycles);
    end
  endtask

  task automatic run_fence(input int exp_mem);
    dtim_pkg::word_t rdata;
    int              cycles;
    int              start;
    start = mem_count;
    cpu_access('0, '0, 4'h0, 1'b1, rdata, cycles);
    if (exp_mem >= 0) begin
      check_count("mem_valid pulses", mem_count - start, exp_mem);
    end
  endtask

  // After a fence memory must match the core's view everywhere.
  task automatic compare_memory();
    for (int i = 0; i < mem_words; i++) begin
      check_word($sformatf("mem[%h]", i * 4), u_mem.mem[i], mirror[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic miss_then_hit();
    read_word(32'h1010, line_words, -1);
    read_word(32'h1018, 0, 1);
  endtask

  task automatic strobed_hit_write();
    write_word(32'h1014, 32'hA1B2C3D4, 4'b0101, 0, 2);
    read_word(32'h1014, 0, 1);
    write_word(32'h101C, 32'h77EE0000, 4'b1000, 0, 2);
    read_word(32'h101C, 0, 1);
  endtask

  task automatic conflict_bypass();
    // Tag 0x11 maps onto index 1, held by tag 0x10.
    read_word(32'h1118, 1, -1);
    write_word(32'h1114, 32'h0BADF00D, 4'b0011, 1, -1);
    check_word("mem @1114", u_mem.mem[mirror_slot(32'h1114)],
               mirror[mirror_slot(32'h1114)]);
    read_word(32'h1114, 1, -1);
    read_word(32'h1014, 0, 1);
  endtask

  task automatic pass_through();
    read_word(32'h0800, 1, -1);
    write_word(32'h0804, 32'h12345678, 4'hf, 1, -1);
    read_word(32'h0804, 1, -1);
    read_word(base_addr - 4, 1, -1);
    read_word(top_addr, 1, -1);
    write_word(top_addr + 8, 32'hCAFEBABE, 4'b1001, 1, -1);
    read_word(top_addr + 8, 1, -1);
  endtask

  task automatic fence_writeback();
    // Index 2 stays clean, index 3 is dirtied by a store miss.
    read_word(32'h1020, line_words, -1);
    write_word(32'h1034, 32'h55667788, 4'b1100, line_words, -1);
    run_fence(2 * line_words);
    compare_memory();
    read_word(32'h1014, line_words, -1);
    read_word(32'h1034, line_words, -1);
  endtask

  task automatic random_mix();
    dtim_pkg::addr_t addr;
    dtim_pkg::addr_t region_base;
    dtim_pkg::word_t data;
    dtim_pkg::strb_t strb;
    int              region;
    for (int n = 0; n < 200; n++) begin
      region = $unsigned($random(seed)) % 4;
      case (region)
        0:       region_base = base_addr;
        1:       region_base = base_addr + 32'h100;
        2:       region_base = base_addr - 32'h100;
        default: region_base = top_addr;
      endcase
      addr = region_base + (($unsigned($random(seed)) % 16) * 4);
      if ($random(seed) & 1) begin
        strb = $random(seed);
        if (strb == 4'h0) begin
          strb = 4'hf;
        end
        data = $random(seed);
        write_word(addr, data, strb, -1, -1);
      end else begin
        read_word(addr, -1, -1);
      end
    end
    run_fence(-1);
    compare_memory();
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////

  initial begin
    rst       = 1'b0;
    cpu_valid = 1'b0;
    cpu_fence = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    cpu_wstrb = '0;
    seed      = 42063;
    for (int i = 0; i < mem_words; i++) begin
      mirror[i] = dtim_pkg::word_t'(i * 4) ^ 32'h5A5A0000;
    end
    repeat (3) @(negedge clk);
    rst = 1'b1;

    miss_then_hit();
    strobed_hit_write();
    conflict_bypass();
    pass_through();
    fence_writeback();
    random_mix();

    assert_fails = u_dut.u_assert.fail_count;
    $display("Errors: %0d check, %0d assertion", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog: the run did not finish within %0d cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
design/dtim_pkg.sv
design/dtim_array.sv
design/dtim_ctrl.sv
design/dtim.sv
bench/dtim_mem_model.sv
bench/dtim_assert.sv
bench/dtim_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the DTIM testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module dtim_tb -f src.f -o sim_dtim

# Let assertion errors reach the testbench's own report.
./obj_dir/sim_dtim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
  exit 0
fi
exit 1
